/* Bender.yml */
package:
  name: frontend

export_include_dirs:
  - common

sources:
  - common/frontend_pkg.sv
  - fetch/rv_predecode.sv
  - fetch/fetch_stage.sv
  - verilog/fetch_queue.sv
  - verilog/instr_decode.sv
  - verilog/frontend_top.sv
  - target: test
    files:
      - test/frontend_asserts.sv
      - test/frontend_tb.sv

/* all.f */
+incdir+common
common/frontend_pkg.sv
fetch/rv_predecode.sv
fetch/fetch_stage.sv
verilog/fetch_queue.sv
verilog/instr_decode.sv
verilog/frontend_top.sv
test/frontend_asserts.sv
test/frontend_tb.sv

/* common/frontend_defs.svh */
// front end configuration constants
// widths, boot address, queue depth and the canonical NOP

`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// PC and data word width
`define XLEN 32

// boot address
`define RESET_PC 32'h0000_0000

// fetch queue entries, power of two
`define FQ_DEPTH 4

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* common/frontend_pkg.sv */
// shared types for the instruction fetch front end
// AXI read channel structs, fetch and decoded records, op classes

`default_nettype none

`include "frontend_defs.svh"

package frontend_pkg;

  // AR channel payload
  typedef struct packed {
    logic [`XLEN-1:0] araddr;
    logic [2:0]       arprot;
  } axi_ar_t;

  // R channel payload
  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic [1:0]       rresp;
  } axi_r_t;

  localparam logic [1:0] resp_okay = 2'b00;

  // one record per fetched instruction
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;       // upper half zero when compressed
    logic             compressed;
    logic             br;
    logic             jump;
  } fetch_rec_t;

  typedef enum logic [3:0] {
    op_alu,
    op_alu_imm,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr,
    op_lui,
    op_auipc,
    op_system,
    op_compressed,
    op_illegal
  } op_class_e;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    op_class_e        op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [31:0]      imm;         // sign extended per format
    logic [31:0]      raw;
  } decoded_t;

  // RV32I major opcodes
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

endpackage

`default_nettype wire

/* fetch/fetch_stage.sv */
// fetch stage, keeps the PC and issues one AXI4-Lite read at a time
// follows direct jumps and pushes one fetch record per instruction

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module fetch_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect_valid,
  input  logic [`XLEN-1:0]         redirect_pc,
  output logic                     arvalid,
  input  logic                     arready,
  output frontend_pkg::axi_ar_t    ar,
  input  logic                     rvalid,
  output logic                     rready,
  input  frontend_pkg::axi_r_t     r,
  output logic                     push,
  output frontend_pkg::fetch_rec_t push_data,
  input  logic                     full
);
  import frontend_pkg::*;

  localparam logic [2:0] arprot_instr = 3'b100;  // unprivileged, secure, instruction

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rd_addr;      // address of the issued read
  logic             rd_pend;      // AR accepted, R not yet
  logic             drop;         // response belongs to a stale stream
  logic             busy;
  logic             ar_hs;
  logic             r_hs;
  logic             issue;
  logic [`XLEN-1:0] next_pc;
  logic [31:0]      word;
  logic             pd_compressed;
  logic             pd_br;
  logic             pd_jump;
  logic [`XLEN-1:0] pd_jump_off;

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;
  assign busy  = arvalid || rd_pend;

  // idle only right after reset, otherwise every response starts the next read
  assign issue = !busy || r_hs;

  assign rready = rd_pend && !full;

  // error responses become an all ones word, decoded as illegal
  assign word = (r.rresp == resp_okay) ? r.rdata : '1;

  rv_predecode u_predecode (
    .instr      (word),
    .compressed (pd_compressed),
    .br         (pd_br),
    .jump       (pd_jump),
    .jump_off   (pd_jump_off)
  );

  // redirect, then jump, then sequential
  always_comb begin
    if (redirect_valid) begin
      next_pc = redirect_pc;
    end else if (!r_hs || drop) begin
      next_pc = pc;                          // first read or after a redirect
    end else if (pd_jump) begin
      next_pc = rd_addr + pd_jump_off;
    end else begin
      next_pc = rd_addr + (pd_compressed ? `XLEN'(2) : `XLEN'(4));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= `RESET_PC;
      rd_addr <= `RESET_PC;
      arvalid <= 1'b0;
      rd_pend <= 1'b0;
      drop    <= 1'b0;
    end else begin
      if (redirect_valid || issue) begin
        pc <= next_pc;
      end

      // pending AR holds its address until accepted
      if (issue) begin
        arvalid <= 1'b1;
        rd_addr <= next_pc;
      end else if (ar_hs) begin
        arvalid <= 1'b0;
      end

      if (ar_hs) begin
        rd_pend <= 1'b1;
      end else if (r_hs) begin
        rd_pend <= 1'b0;
      end

      if (redirect_valid && busy && !r_hs) begin
        drop <= 1'b1;
      end else if (r_hs) begin
        drop <= 1'b0;
      end
    end
  end

  assign ar.araddr = rd_addr;
  assign ar.arprot = arprot_instr;

  // a response in the redirect cycle is stale too
  assign push = r_hs && !drop && !redirect_valid;

  assign push_data.pc         = rd_addr;
  assign push_data.instr      = pd_compressed ? {16'h0000, word[15:0]} : word;
  assign push_data.compressed = pd_compressed;
  assign push_data.br         = pd_br;
  assign push_data.jump       = pd_jump;

endmodule

`default_nettype wire

/* fetch/rv_predecode.sv */
// predecoder for RV32IC fetch words
// flags compressed, branch and direct jump, extracts the jump offset

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module rv_predecode (
  input  logic [31:0]       instr,
  output logic              compressed,
  output logic              br,
  output logic              jump,
  output logic [`XLEN-1:0]  jump_off
);
  import frontend_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       c_funct3;
  logic             c_quad1;
  logic             is_jal;
  logic             is_branch;
  logic             is_cj;
  logic             is_cb;
  logic [`XLEN-1:0] jal_imm;
  logic [`XLEN-1:0] cj_imm;

  assign compressed = ~(instr[1] & instr[0]);
  assign opcode     = instr[6:0];
  assign c_funct3   = instr[15:13];
  assign c_quad1    = (instr[1:0] == 2'b01);

  assign is_jal    = !compressed && (opcode == opc_jal);
  assign is_branch = !compressed && (opcode == opc_branch);
  assign is_cj     = c_quad1 && (c_funct3 == 3'b101);
  // c.beqz and c.bnez
  assign is_cb     = c_quad1 && (c_funct3 == 3'b110 || c_funct3 == 3'b111);

  assign br   = is_branch || is_cb;
  assign jump = is_jal || is_cj;

  // J format, imm[20|10:1|11|19:12]
  assign jal_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

  // CJ format, offset[11|4|9:8|10|6|7|3:1|5]
  assign cj_imm = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7],
                   instr[2], instr[11], instr[5:3], 1'b0};

  assign jump_off = is_cj ? cj_imm : jal_imm;  // only meaningful with jump

endmodule

`default_nettype wire

/* test/frontend_asserts.sv */
// handshake assertions for the front end, bound to frontend_top

`timescale 1ns/1ps
`default_nettype none

module frontend_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   redirect_valid,
  input logic                   arvalid,
  input logic                   arready,
  input frontend_pkg::axi_ar_t  ar,
  input logic                   rvalid,
  input logic                   rready,
  input logic                   dec_valid,
  input logic                   dec_ready,
  input frontend_pkg::decoded_t dec
);

  logic outstanding;  // AR accepted, R still open

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (arvalid && arready) begin
      outstanding <= 1'b1;
    end else if (rvalid && rready) begin
      outstanding <= 1'b0;
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("AR request changed before arready");

  // a redirect may legally flush the output
  dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && !dec_ready && !redirect_valid |=> dec_valid && $stable(dec))
    else $error("decoded output changed while stalled");

  one_read: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && arready |-> !outstanding)
    else $error("second read issued before the response was accepted");

endmodule

bind frontend_top frontend_asserts asserts_i (
  .clk(clk), .rst_n(rst_n), .redirect_valid(redirect_valid), .arvalid(arvalid),
  .arready(arready), .ar(ar), .rvalid(rvalid), .rready(rready),
  .dec_valid(dec_valid), .dec_ready(dec_ready), .dec(dec)
);

`default_nettype wire

/* test/frontend_tb.sv */
// testbench for the fetch front end
// AXI read memory model, directed program tests, compare tasks and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module frontend_tb;
  import frontend_pkg::*;

  localparam int total_instr = 100;  // all tests together, rounded up
  localparam longint watchdog_ns = (total_instr * 40 + 500) * 20;

  logic clk;
  logic rst_n;
  logic redirect_valid;
  logic [`XLEN-1:0] redirect_pc;
  logic arvalid;
  logic arready;
  axi_ar_t ar;
  logic rvalid;
  logic rready;
  axi_r_t r;
  logic dec_valid;
  logic dec_ready;
  decoded_t dec;

  logic [7:0] mem [4096];
  decoded_t exp_q[$];
  decoded_t got[$];
  logic [`XLEN-1:0] ar_log[$];
  logic [`XLEN-1:0] epc;          // where the next instruction is placed
  logic [`XLEN-1:0] err_addr;
  logic err_en;
  logic bp_mode;
  int errors;
  int tests_ok;
  int tests_bad;

  frontend_top dut_i (
    .clk(clk), .rst_n(rst_n), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .arvalid(arvalid), .arready(arready), .ar(ar), .rvalid(rvalid), .rready(rready),
    .r(r), .dec_valid(dec_valid), .dec_ready(dec_ready), .dec(dec)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  // memory model and output sink, all random draws live here
  initial begin : axi_mem_model
    int unsigned delay;
    int unsigned stall;
    logic r_pend;
    logic r_done;
    logic [11:0] a;
    void'($urandom(32'h03ea_1c11));
    arready = 1'b0;
    rvalid = 1'b0;
    r = '0;
    dec_ready = 1'b0;
    r_pend = 1'b0;
    r_done = 1'b0;
    delay = 0;
    stall = 0;
    a = '0;
    forever begin
      @(negedge clk);
      if (r_done) begin
        rvalid = 1'b0;
        r_pend = 1'b0;
        r_done = 1'b0;
      end
      if (r_pend && !rvalid) begin
        if (delay == 0) begin
          rvalid  = 1'b1;
          r.rdata = {mem[a + 12'd3], mem[a + 12'd2], mem[a + 12'd1], mem[a]};
          r.rresp = (err_en && {20'h0, a} == err_addr) ? 2'b10 : 2'b00;
        end else begin
          delay--;
        end
      end
      if (rvalid && rready) r_done = 1'b1;  // transfers on the coming edge
      arready = !r_pend && ($urandom % 4 != 0);
      if (arvalid && arready) begin
        r_pend = 1'b1;
        a      = ar.araddr[11:0];
        delay  = $urandom % 4;
        ar_log.push_back(ar.araddr);
        check_prot(ar.arprot);
      end
      if (!bp_mode) begin
        dec_ready = 1'b1;
      end else if (stall > 0) begin
        dec_ready = 1'b0;
        stall--;
      end else if ($urandom % 8 == 0) begin
        stall     = 4 + $urandom % 10;
        dec_ready = 1'b0;
      end else begin
        dec_ready = 1'b1;
      end
      if (dec_valid && dec_ready) got.push_back(dec);
    end
  end

  task automatic check_decoded(input int idx, input decoded_t g, input decoded_t e);
    if (g.pc !== e.pc) begin
      $display("Mismatch dec.pc (record %0d): got %h expected %h", idx, g.pc, e.pc);
      errors++;
    end
    if (g.op !== e.op) begin
      $display("Mismatch dec.op (record %0d): got %h expected %h", idx, g.op, e.op);
      errors++;
    end
    if ({g.rd, g.rs1, g.rs2} !== {e.rd, e.rs1, e.rs2}) begin
      $display("Mismatch dec.rd/rs1/rs2 (record %0d): got %h %h %h expected %h %h %h",
               idx, g.rd, g.rs1, g.rs2, e.rd, e.rs1, e.rs2);
      errors++;
    end
    if (g.imm !== e.imm) begin
      $display("Mismatch dec.imm (record %0d): got %h expected %h", idx, g.imm, e.imm);
      errors++;
    end
    if (g.raw !== e.raw) begin
      $display("Mismatch dec.raw (record %0d): got %h expected %h", idx, g.raw, e.raw);
      errors++;
    end
  endtask

  task automatic check_addr(input logic [`XLEN-1:0] g, input logic [`XLEN-1:0] e);
    if (g !== e) begin
      $display("Mismatch ar.araddr: got %h expected %h", g, e);
      errors++;
    end
  endtask

  // bit 2 marks an instruction access
  task automatic check_prot(input logic [2:0] g);
    if (g[2] !== 1'b1) begin
      $display("Mismatch ar.arprot[2]: got %h expected %h", g[2], 1'b1);
      errors++;
    end
  endtask

  // address of the read issued right after the one at a
  function automatic logic [`XLEN-1:0] addr_after(input logic [`XLEN-1:0] a);
    for (int i = 0; i + 1 < ar_log.size(); i++) begin
      if (ar_log[i] == a) return ar_log[i + 1];
    end
    return 32'hffff_fffe;
  endfunction

  task automatic fill_mem();
    logic [31:0] w;
    for (int i = 0; i < 4096; i += 4) begin
      w = {2'b00, 10'(i >> 2), 5'd0, 3'd0, 5'd0, 7'h13};  // addi x0, x0, word index
      {mem[i + 3], mem[i + 2], mem[i + 1], mem[i]} = w;
    end
    exp_q.delete();
  endtask

  task automatic put_half(input logic [`XLEN-1:0] a, input logic [15:0] h);
    mem[a[11:0]]         = h[7:0];
    mem[a[11:0] + 12'd1] = h[15:8];
  endtask

  task automatic emit32(input logic [31:0] w, input decoded_t e);
    put_half(epc, w[15:0]);
    put_half(epc + 2, w[31:16]);
    e.pc  = epc;
    e.raw = w;
    exp_q.push_back(e);
    epc += 4;
  endtask

  task automatic emit_r(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    decoded_t e;
    e = '0;
    e.op  = op_alu;
    e.rd  = rd;
    e.rs1 = rs1;
    e.rs2 = rs2;
    emit32({7'h00, rs2, rs1, 3'b000, rd, 7'b0110011}, e);
  endtask

  // addi or lw
  task automatic emit_i(input op_class_e op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    decoded_t e;
    logic [6:0] opc;
    e = '0;
    e.op  = op;
    e.rd  = rd;
    e.rs1 = rs1;
    e.imm = {{20{imm[11]}}, imm};
    opc = (op == op_load) ? 7'b0000011 : 7'b0010011;
    emit32({imm, rs1, (op == op_load) ? 3'b010 : 3'b000, rd, opc}, e);
  endtask

  task automatic emit_s(input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
    decoded_t e;
    e = '0;
    e.op  = op_store;
    e.rs1 = rs1;
    e.rs2 = rs2;
    e.imm = {{20{imm[11]}}, imm};
    emit32({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, e);
  endtask

  task automatic emit_u(input op_class_e op, input logic [4:0] rd, input logic [19:0] imm);
    decoded_t e;
    e = '0;
    e.op  = op;
    e.rd  = rd;
    e.imm = {imm, 12'h000};
    emit32({imm, rd, (op == op_lui) ? 7'b0110111 : 7'b0010111}, e);
  endtask

  // beq, never taken here
  task automatic emit_b(input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] off);
    decoded_t e;
    e = '0;
    e.op  = op_branch;
    e.rs1 = rs1;
    e.rs2 = rs2;
    e.imm = {{19{off[12]}}, off};
    emit32({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011}, e);
  endtask

  task automatic emit_jal(input logic [4:0] rd, input logic [20:0] off);
    decoded_t e;
    logic [`XLEN-1:0] here;
    e = '0;
    here = epc;
    e.op  = op_jal;
    e.rd  = rd;
    e.imm = {{11{off[20]}}, off};
    emit32({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}, e);
    epc = here + e.imm;
  endtask

  task automatic emit_c(input logic [15:0] h);
    decoded_t e;
    e = '0;
    e.op  = op_compressed;
    e.pc  = epc;
    e.raw = {16'h0000, h};
    put_half(epc, h);
    exp_q.push_back(e);
    epc += 2;
  endtask

  task automatic emit_cj(input logic [11:0] off);
    logic [`XLEN-1:0] here;
    here = epc;
    emit_c({3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5],
            2'b01});
    epc = here + {{20{off[11]}}, off};
  endtask

  // slot answered with an error response
  task automatic emit_err();
    decoded_t e;
    e = '0;
    e.op  = op_illegal;
    e.pc  = epc;
    e.raw = '1;
    err_addr = epc;
    err_en   = 1'b1;
    exp_q.push_back(e);
    epc += 4;
  endtask

  task automatic start_stream(input logic [`XLEN-1:0] a);
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_pc    = a;
    @(posedge clk);
    ar_log.delete();  // older reads and records end here
    got.delete();
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  task automatic wait_records(input int n);
    int cyc;
    cyc = 0;
    while (got.size() < n && cyc < n * 40 + 200) begin
      @(negedge clk);
      cyc++;
    end
    if (got.size() < n) begin
      $display("timeout: only %0d of %0d decoded records arrived", got.size(), n);
      errors++;
    end
  endtask

  // one record past the program shows nothing was repeated at its end
  task automatic compare_stream();
    wait_records(exp_q.size() + 1);
    for (int i = 0; i < exp_q.size() && i < got.size(); i++) begin
      check_decoded(i, got[i], exp_q[i]);
    end
    if (got.size() > exp_q.size() && got[exp_q.size()].pc !== epc) begin
      $display("Mismatch dec.pc (record after the program): got %h expected %h",
               got[exp_q.size()].pc, epc);
      errors++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
      tests_bad++;
    end
  endtask

  task automatic test_sequential();
    int e0;
    e0 = errors;
    fill_mem();
    epc = `RESET_PC;
    emit_i(op_alu_imm, 5'd1, 5'd0, 12'h005);
    emit_u(op_lui, 5'd2, 20'h12345);
    emit_r(5'd3, 5'd1, 5'd2);
    emit_i(op_load, 5'd4, 5'd2, 12'hff8);
    emit_s(5'd2, 5'd4, 12'h804);
    emit_u(op_auipc, 5'd5, 20'hfffff);
    emit_i(op_alu_imm, 5'd6, 5'd5, 12'h7ff);
    emit_r(5'd7, 5'd6, 5'd3);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_stream();
    if (ar_log.size() == 0) begin
      $display("no read address was issued after reset");
      errors++;
    end else begin
      check_addr(ar_log[0], `RESET_PC);
    end
    report("sequential", e0);
  endtask

  task automatic test_mixed();
    int e0;
    e0 = errors;
    fill_mem();
    epc = 32'h100;
    emit_c(16'h0505);                   // c.addi
    emit_r(5'd8, 5'd9, 5'd10);          // at pc 2 mod 4
    emit_c(16'h852e);                   // c.mv
    emit_c(16'h0505);
    emit_i(op_load, 5'd11, 5'd8, 12'h010);
    emit_u(op_lui, 5'd12, 20'habcde);
    emit_c(16'h852e);
    emit_s(5'd12, 5'd11, 12'h020);
    emit_r(5'd13, 5'd12, 5'd11);
    start_stream(32'h100);
    compare_stream();
    report("mixed", e0);
  endtask

  task automatic test_jumps();
    int e0;
    logic [`XLEN-1:0] jal_pc;
    logic [`XLEN-1:0] br_pc;
    logic [`XLEN-1:0] cj_pc;
    e0 = errors;
    fill_mem();
    epc = 32'h200;
    emit_r(5'd1, 5'd2, 5'd3);
    jal_pc = epc;
    emit_jal(5'd1, 21'h40);
    emit_i(op_alu_imm, 5'd2, 5'd2, 12'h001);
    br_pc = epc;
    emit_b(5'd1, 5'd2, 13'h010);
    emit_r(5'd4, 5'd1, 5'd2);
    emit_c(16'h0505);
    cj_pc = epc;
    emit_cj(12'h020);
    emit_r(5'd5, 5'd4, 5'd1);
    emit_i(op_alu_imm, 5'd6, 5'd5, 12'hfff);
    start_stream(32'h200);
    compare_stream();
    check_addr(addr_after(jal_pc), jal_pc + 32'h40);
    check_addr(addr_after(br_pc), br_pc + 32'h4);
    check_addr(addr_after(cj_pc), cj_pc + 32'h20);
    report("jumps", e0);
  endtask

  task automatic test_redirect();
    int e0;
    e0 = errors;
    fill_mem();
    epc = 32'h400;
    for (int i = 0; i < 16; i++) emit_i(op_alu_imm, 5'(i + 1), 5'd0, 12'(i));
    start_stream(32'h400);
    wait_records(3);
    for (int i = 0; i < 3 && i < got.size(); i++) check_decoded(i, got[i], exp_q[i]);
    exp_q.delete();
    epc = 32'h600;
    emit_r(5'd1, 5'd2, 5'd3);
    emit_c(16'h852e);
    emit_s(5'd1, 5'd2, 12'h00c);
    emit_u(op_auipc, 5'd7, 20'h00010);
    emit_i(op_load, 5'd9, 5'd1, 12'h004);
    start_stream(32'h600);
    compare_stream();
    report("redirect", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    fill_mem();
    epc = 32'h800;
    for (int i = 0; i < 32; i++) begin
      case (i % 4)
        0: emit_r(5'(i), 5'(i + 1), 5'(i + 2));
        1: emit_c(16'h0505);
        2: emit_i(op_alu_imm, 5'(i), 5'(i + 3), 12'(i * 37));
        default: emit_s(5'(i), 5'(i + 5), 12'(i * 11));
      endcase
    end
    bp_mode = 1'b1;
    start_stream(32'h800);
    compare_stream();
    bp_mode = 1'b0;
    report("backpressure", e0);
  endtask

  task automatic test_error_resp();
    int e0;
    e0 = errors;
    fill_mem();
    epc = 32'ha00;
    emit_r(5'd1, 5'd2, 5'd3);
    emit_i(op_alu_imm, 5'd2, 5'd1, 12'h010);
    emit_err();
    emit_r(5'd4, 5'd2, 5'd1);
    emit_c(16'h0505);
    emit_i(op_load, 5'd5, 5'd4, 12'h008);
    start_stream(32'ha00);
    compare_stream();
    err_en = 1'b0;
    report("error_resp", e0);
  endtask

  initial begin : main
    rst_n = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    err_addr = '0;
    err_en = 1'b0;
    bp_mode = 1'b0;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    test_sequential();
    test_mixed();
    test_jumps();
    test_redirect();
    test_backpressure();
    test_error_resp();
    $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fetch_queue.sv */
// fetch queue, circular buffer with first-word-fall-through read
// payload type and depth are parameters, flush empties it

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module fetch_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = `FQ_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  // extra pointer bit tells full from empty
  localparam int PW = $clog2(DEPTH) + 1;
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] count;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;
  logic          do_push;
  logic          do_pop;

  assign count = wr_ptr - rd_ptr;
  assign full  = (count == PW'(DEPTH));
  assign empty = (count == '0);

  assign wr_idx = AW'(wr_ptr % DEPTH);
  assign rd_idx = AW'(rd_ptr % DEPTH);

  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);  // full queue takes a push with a pop

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push && !flush) begin
      mem[wr_idx] <= push_data;
    end
  end

  assign pop_data = mem[rd_idx];  // valid while not empty

endmodule

`default_nettype wire

/* verilog/frontend_top.sv */
// instruction fetch front end top
// fetch stage feeds the fetch queue, decode drains it

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module frontend_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_valid,
  input  logic [`XLEN-1:0]       redirect_pc,
  output logic                   arvalid,
  input  logic                   arready,
  output frontend_pkg::axi_ar_t  ar,
  input  logic                   rvalid,
  output logic                   rready,
  input  frontend_pkg::axi_r_t   r,
  output logic                   dec_valid,
  input  logic                   dec_ready,
  output frontend_pkg::decoded_t dec
);
  import frontend_pkg::*;

  logic       push;
  fetch_rec_t push_data;
  logic       full;
  logic       pop;
  fetch_rec_t pop_data;
  logic       empty;

  fetch_stage u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .arvalid        (arvalid),
    .arready        (arready),
    .ar             (ar),
    .rvalid         (rvalid),
    .rready         (rready),
    .r              (r),
    .push           (push),
    .push_data      (push_data),
    .full           (full)
  );

  // redirect doubles as queue flush
  fetch_queue #(
    .payload_t (fetch_rec_t),
    .DEPTH     (`FQ_DEPTH)
  ) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (redirect_valid),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty)
  );

  instr_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (redirect_valid),
    .empty     (empty),
    .pop       (pop),
    .pop_data  (pop_data),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec)
  );

endmodule

`default_nettype wire

/* verilog/instr_decode.sv */
// RV32I decode stage with a registered output and valid/ready handshake
// compressed records pass through raw, unknown opcodes are illegal

`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module instr_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     empty,
  output logic                     pop,
  input  frontend_pkg::fetch_rec_t pop_data,
  output logic                     dec_valid,
  input  logic                     dec_ready,
  output frontend_pkg::decoded_t   dec
);
  import frontend_pkg::*;

  localparam decoded_t nop_rec = '{pc: '0, op: op_alu_imm, rd: '0, rs1: '0, rs2: '0,
                                   imm: '0, raw: `NOP_INSTR};

  decoded_t    dec_next;
  logic [31:0] ins;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign ins   = pop_data.instr;
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'h000};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  // register fields only where the format has them
  always_comb begin
    dec_next     = '0;
    dec_next.pc  = pop_data.pc;
    dec_next.raw = ins;
    if (pop_data.compressed) begin
      dec_next.op = op_compressed;
    end else begin
      case (ins[6:0])
        opc_op:     dec_next = '{pop_data.pc, op_alu, ins[11:7], ins[19:15], ins[24:20],
                                 32'h0, ins};
        opc_op_imm: dec_next = '{pop_data.pc, op_alu_imm, ins[11:7], ins[19:15], 5'd0,
                                 imm_i, ins};
        opc_load:   dec_next = '{pop_data.pc, op_load, ins[11:7], ins[19:15], 5'd0,
                                 imm_i, ins};
        opc_store:  dec_next = '{pop_data.pc, op_store, 5'd0, ins[19:15], ins[24:20],
                                 imm_s, ins};
        opc_branch: dec_next = '{pop_data.pc, op_branch, 5'd0, ins[19:15], ins[24:20],
                                 imm_b, ins};
        opc_jal:    dec_next = '{pop_data.pc, op_jal, ins[11:7], 5'd0, 5'd0, imm_j, ins};
        opc_jalr:   dec_next = '{pop_data.pc, op_jalr, ins[11:7], ins[19:15], 5'd0,
                                 imm_i, ins};
        opc_lui:    dec_next = '{pop_data.pc, op_lui, ins[11:7], 5'd0, 5'd0, imm_u, ins};
        opc_auipc:  dec_next = '{pop_data.pc, op_auipc, ins[11:7], 5'd0, 5'd0, imm_u, ins};
        opc_system: dec_next = '{pop_data.pc, op_system, ins[11:7], ins[19:15], 5'd0,
                                 imm_i, ins};
        default:    dec_next.op = op_illegal;
      endcase
    end
  end

  // take the head only when the output slot frees up this cycle
  assign pop = !empty && !flush && (!dec_valid || dec_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      dec       <= nop_rec;
    end else if (flush) begin
      dec_valid <= 1'b0;
      dec       <= nop_rec;
    end else if (pop) begin
      dec_valid <= 1'b1;
      dec       <= dec_next;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;     // taken, nothing new
    end
  end

endmodule

`default_nettype wire
